//--- Bender.yml
package:
  name: rvj1

sources:
  - common/rvj1_pkg.sv
  - ifu/rvj1_ifu.sv
  - dec/rvj1_dec.sv
  - rtl/rvj1_regfile.sv
  - rtl/rvj1_alu.sv
  - lsu/rvj1_lsu.sv
  - rtl/rvj1_top.sv
  - target: test
    files:
      - verif/rvj1_asserts.sv
      - verif/rvj1_tb.sv

//--- common/rvj1_pkg.sv
/*
  Shared widths, vector types, opcode and ALU encodings, and the bus and
  issue structs of the rvj1 core. Every RTL file refers to these by
  scoped names.
*/

package rvj1_pkg;

  localparam int unsigned xlen   = 32;
  localparam int unsigned nbytes = 4;
  localparam int unsigned ralen  = 5;

  typedef logic [xlen-1:0]   word_t;
  typedef logic [ralen-1:0]  reg_addr_t;
  typedef logic [nbytes-1:0] strobe_t;

  // RV32I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_e;

  // Request side of a memory bus
  typedef struct packed {
    word_t   addr;
    word_t   data;
    strobe_t strobe;
    logic    write;
  } mem_req_t;

  typedef struct packed {
    word_t data;
    logic  error;
  } mem_rsp_t;

  // Decoded instruction handed to execute
  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_pc;
    logic      use_imm;
    word_t     imm;
    reg_addr_t rd;
    logic      alu_wb;
    logic      is_load;
    logic      is_store;
    logic      is_jump;
    word_t     pc;
  } issue_t;

endpackage

//--- dec/rvj1_dec.sv
/*
  Decoder and issue stage. Turns a fetched word into an issue record,
  holds it for one cycle, and stalls fetch on a busy source register
  or a busy load/store unit. JAL redirects fetch in its issue cycle.
*/

module rvj1_dec (
  input  logic                clk_i,
  input  logic                rst_i,
  input  rvj1_pkg::word_t     ifu_instr_i,
  input  rvj1_pkg::word_t     ifu_pc_i,
  input  logic                ifu_valid_i,
  output logic                ifu_ready_o,
  input  logic                lsu_busy_i,
  input  logic                wb_valid_i,
  input  rvj1_pkg::reg_addr_t wb_rd_i,
  output rvj1_pkg::reg_addr_t rs1_o,
  output rvj1_pkg::reg_addr_t rs2_o,
  output rvj1_pkg::issue_t    issue_o,
  output logic                issue_valid_o,
  output logic                jump_valid_o,
  output rvj1_pkg::word_t     jump_addr_o
);

  rvj1_pkg::reg_addr_t          rs1;
  rvj1_pkg::reg_addr_t          rs2;
  rvj1_pkg::reg_addr_t          rd;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  rvj1_pkg::word_t              imm_i;
  rvj1_pkg::word_t              imm_s;
  rvj1_pkg::word_t              imm_u;
  rvj1_pkg::word_t              imm_j;
  rvj1_pkg::issue_t             issue_d;
  logic [(1<<rvj1_pkg::ralen)-1:0] busy_q;
  logic                         accept;

  assign rs1    = ifu_instr_i[19:15];
  assign rs2    = ifu_instr_i[24:20];
  assign rd     = ifu_instr_i[11:7];
  assign funct3 = ifu_instr_i[14:12];
  assign funct7 = ifu_instr_i[31:25];

  assign imm_i = {{20{ifu_instr_i[31]}}, ifu_instr_i[31:20]};
  assign imm_s = {{20{ifu_instr_i[31]}}, ifu_instr_i[31:25], ifu_instr_i[11:7]};
  assign imm_u = {ifu_instr_i[31:12], 12'b0};
  assign imm_j = {{12{ifu_instr_i[31]}}, ifu_instr_i[19:12], ifu_instr_i[20],
                  ifu_instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////
  always_comb begin
    issue_d    = '0;
    issue_d.rd = rd;
    issue_d.pc = ifu_pc_i;
    case (rvj1_pkg::opcode_e'(ifu_instr_i[6:0]))
      rvj1_pkg::opc_op: begin
        issue_d.alu_wb = 1'b1;
        case (funct3)
          3'b000:  issue_d.alu_op = funct7[5] ? rvj1_pkg::alu_sub : rvj1_pkg::alu_add;
          3'b100:  issue_d.alu_op = rvj1_pkg::alu_xor;
          3'b110:  issue_d.alu_op = rvj1_pkg::alu_or;
          3'b111:  issue_d.alu_op = rvj1_pkg::alu_and;
          default: issue_d.alu_wb = 1'b0;
        endcase
      end
      rvj1_pkg::opc_op_imm: begin
        // Only ADDI, the other encodings fall through as no-ops
        issue_d.use_imm = 1'b1;
        issue_d.imm     = imm_i;
        issue_d.alu_wb  = (funct3 == 3'b000);
      end
      rvj1_pkg::opc_lui: begin
        issue_d.alu_op  = rvj1_pkg::alu_pass_b;
        issue_d.use_imm = 1'b1;
        issue_d.imm     = imm_u;
        issue_d.alu_wb  = 1'b1;
      end
      rvj1_pkg::opc_load: begin
        issue_d.use_imm = 1'b1;
        issue_d.imm     = imm_i;
        issue_d.is_load = 1'b1;
      end
      rvj1_pkg::opc_store: begin
        issue_d.use_imm  = 1'b1;
        issue_d.imm      = imm_s;
        issue_d.is_store = 1'b1;
      end
      rvj1_pkg::opc_jal: begin
        issue_d.use_pc  = 1'b1;
        issue_d.use_imm = 1'b1;
        issue_d.imm     = imm_j;
        issue_d.is_jump = 1'b1;
      end
      default: begin
      end
    endcase
  end

  ////////////////////////////////////////////////////
  // Scoreboard and issue register
  ////////////////////////////////////////////////////
  assign ifu_ready_o = !(lsu_busy_i || busy_q[rs1] || busy_q[rs2]);
  assign accept      = ifu_valid_i && ifu_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_valid_o <= 1'b0;
      busy_q        <= '0;
    end else begin
      issue_valid_o <= accept;
      if (wb_valid_i) begin
        busy_q[wb_rd_i] <= 1'b0;
      end
      // x0 never becomes busy
      if (accept && issue_d.is_load && rd != '0) begin
        busy_q[rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_o <= issue_d;
      rs1_o   <= rs1;
      rs2_o   <= rs2;
    end
  end

  assign jump_valid_o = issue_valid_o && issue_o.is_jump;
  assign jump_addr_o  = issue_o.pc + issue_o.imm;

endmodule

//--- ifu/rvj1_ifu.sv
/*
  Instruction fetch unit. Keeps the PC, runs one fetch at a time on the
  instruction bus and hands each word to the decoder. A jump redirect
  drops any response still owed to a fetch made before it.
*/

module rvj1_ifu (
  input  logic               clk_i,
  input  logic               rst_i,
  output rvj1_pkg::mem_req_t instr_req_o,
  output logic               instr_req_valid_o,
  input  logic               instr_req_ready_i,
  input  rvj1_pkg::mem_rsp_t instr_rsp_i,
  input  logic               instr_rsp_valid_i,
  output logic               instr_rsp_ready_o,
  output rvj1_pkg::word_t    dec_instr_o,
  output rvj1_pkg::word_t    dec_pc_o,
  output logic               dec_valid_o,
  input  logic               dec_ready_i,
  input  logic               jump_valid_i,
  input  rvj1_pkg::word_t    jump_addr_i
);

  typedef enum logic [1:0] {
    ifu_idle,
    ifu_req,
    ifu_wait,
    ifu_hold
  } state_e;

  state_e          state_q;
  rvj1_pkg::word_t pc_q;
  rvj1_pkg::word_t instr_q;
  rvj1_pkg::word_t redir_q;
  logic            discard_q;

  // Read-only fetch of the word at the PC
  assign instr_req_o       = '{addr: pc_q, data: '0, strobe: '1, write: 1'b0};
  assign instr_req_valid_o = (state_q == ifu_req);
  assign instr_rsp_ready_o = (state_q == ifu_wait);

  // Nothing is offered to decode in a redirect cycle
  assign dec_valid_o = ((state_q == ifu_wait && instr_rsp_valid_i && !discard_q) ||
                        state_q == ifu_hold) && !jump_valid_i;
  assign dec_instr_o = (state_q == ifu_hold) ? instr_q : instr_rsp_i.data;
  assign dec_pc_o    = pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ifu_idle;
      pc_q      <= '0;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        ifu_idle: begin
          state_q <= ifu_req;
        end
        ifu_req: begin
          // Request must stay put, so the stale reply is dropped later
          if (jump_valid_i) begin
            discard_q <= 1'b1;
          end
          if (instr_req_ready_i) begin
            state_q <= ifu_wait;
          end
        end
        ifu_wait: begin
          if (instr_rsp_valid_i) begin
            if (discard_q || jump_valid_i) begin
              discard_q <= 1'b0;
              pc_q      <= jump_valid_i ? jump_addr_i : redir_q;
              state_q   <= ifu_req;
            end else if (dec_ready_i) begin
              pc_q    <= pc_q + rvj1_pkg::nbytes;
              state_q <= ifu_req;
            end else begin
              state_q <= ifu_hold;
            end
          end else if (jump_valid_i) begin
            discard_q <= 1'b1;
          end
        end
        ifu_hold: begin
          if (jump_valid_i) begin
            pc_q    <= jump_addr_i;
            state_q <= ifu_req;
          end else if (dec_ready_i) begin
            pc_q    <= pc_q + rvj1_pkg::nbytes;
            state_q <= ifu_req;
          end
        end
        default: begin
          state_q <= ifu_idle;
        end
      endcase
    end
  end

  // Pending target and the word parked while decode is busy
  always_ff @(posedge clk_i) begin
    if (jump_valid_i) begin
      redir_q <= jump_addr_i;
    end
    if (state_q == ifu_wait && instr_rsp_valid_i) begin
      instr_q <= instr_rsp_i.data;
    end
  end

endmodule

//--- lsu/rvj1_lsu.sv
/*
  Load/store unit for word accesses. Latches the command at issue, sends
  one request on the data bus and writes load data back when the
  response arrives. Busy covers the issue cycle as well.
*/

module rvj1_lsu (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                issue_valid_i,
  input  logic                is_load_i,
  input  logic                is_store_i,
  input  rvj1_pkg::word_t     addr_i,
  input  rvj1_pkg::word_t     store_data_i,
  input  rvj1_pkg::reg_addr_t rd_i,
  output logic                busy_o,
  output rvj1_pkg::mem_req_t  data_req_o,
  output logic                data_req_valid_o,
  input  logic                data_req_ready_i,
  input  rvj1_pkg::mem_rsp_t  data_rsp_i,
  input  logic                data_rsp_valid_i,
  output logic                data_rsp_ready_o,
  output logic                wb_valid_o,
  output rvj1_pkg::reg_addr_t wb_rd_o,
  output rvj1_pkg::word_t     wb_data_o
);

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_req,
    lsu_rsp
  } state_e;

  state_e              state_q;
  rvj1_pkg::mem_req_t  req_q;
  rvj1_pkg::reg_addr_t rd_q;
  logic                start;

  assign start = issue_valid_i && (is_load_i || is_store_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= lsu_idle;
    end else begin
      case (state_q)
        lsu_idle: if (start)            state_q <= lsu_req;
        lsu_req:  if (data_req_ready_i) state_q <= lsu_rsp;
        lsu_rsp:  if (data_rsp_valid_i) state_q <= lsu_idle;
        default:                        state_q <= lsu_idle;
      endcase
    end
  end

  // Command and operands, always a full word
  always_ff @(posedge clk_i) begin
    if (start) begin
      req_q <= '{addr: addr_i, data: store_data_i, strobe: '1, write: is_store_i};
      rd_q  <= rd_i;
    end
  end

  assign busy_o           = (state_q != lsu_idle) || start;
  assign data_req_o       = req_q;
  assign data_req_valid_o = (state_q == lsu_req);
  assign data_rsp_ready_o = (state_q == lsu_rsp);

  // Store responses only close the access
  assign wb_valid_o = (state_q == lsu_rsp) && data_rsp_valid_i && !req_q.write;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = data_rsp_i.data;

endmodule

//--- rtl/rvj1_alu.sv
/*
  Combinational ALU for the supported RV32I subset. PASS_B forwards the
  second operand, which LUI uses for its immediate.
*/

module rvj1_alu (
  input  rvj1_pkg::alu_op_e op_i,
  input  rvj1_pkg::word_t   a_i,
  input  rvj1_pkg::word_t   b_i,
  output rvj1_pkg::word_t   res_o
);

  always_comb begin
    case (op_i)
      rvj1_pkg::alu_add:    res_o = a_i + b_i;
      rvj1_pkg::alu_sub:    res_o = a_i - b_i;
      rvj1_pkg::alu_and:    res_o = a_i & b_i;
      rvj1_pkg::alu_or:     res_o = a_i | b_i;
      rvj1_pkg::alu_xor:    res_o = a_i ^ b_i;
      rvj1_pkg::alu_pass_b: res_o = b_i;
      default:              res_o = '0;
    endcase
  end

endmodule

//--- rtl/rvj1_regfile.sv
/*
  Integer register file, two combinational read ports and one write
  port. x0 always reads as zero.
*/

module rvj1_regfile (
  input  logic                clk_i,
  input  logic                rst_i,
  input  rvj1_pkg::reg_addr_t rs1_i,
  input  rvj1_pkg::reg_addr_t rs2_i,
  output rvj1_pkg::word_t     rs1_data_o,
  output rvj1_pkg::word_t     rs2_data_o,
  input  logic                we_i,
  input  rvj1_pkg::reg_addr_t rd_i,
  input  rvj1_pkg::word_t     rd_data_i
);

  rvj1_pkg::word_t regs_q [1:(1<<rvj1_pkg::ralen)-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < (1 << rvj1_pkg::ralen); i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- rtl/rvj1_top.sv
/*
  Top level of the rvj1 core. Ties fetch, decode, register file, ALU and
  load/store unit together and picks the register writeback source.
  Exposes the instruction and data buses as valid/ready pairs.
*/

module rvj1_top (
  input  logic               clk_i,
  input  logic               rst_i,
  output rvj1_pkg::mem_req_t instr_req_o,
  output logic               instr_req_valid_o,
  input  logic               instr_req_ready_i,
  input  rvj1_pkg::mem_rsp_t instr_rsp_i,
  input  logic               instr_rsp_valid_i,
  output logic               instr_rsp_ready_o,
  output rvj1_pkg::mem_req_t data_req_o,
  output logic               data_req_valid_o,
  input  logic               data_req_ready_i,
  input  rvj1_pkg::mem_rsp_t data_rsp_i,
  input  logic               data_rsp_valid_i,
  output logic               data_rsp_ready_o
);

  rvj1_pkg::word_t     fetch_instr;
  rvj1_pkg::word_t     fetch_pc;
  logic                fetch_valid;
  logic                dec_ready;
  logic                jump_valid;
  rvj1_pkg::word_t     jump_addr;
  rvj1_pkg::reg_addr_t rs1;
  rvj1_pkg::reg_addr_t rs2;
  rvj1_pkg::word_t     rs1_data;
  rvj1_pkg::word_t     rs2_data;
  rvj1_pkg::issue_t    issue;
  logic                issue_valid;
  rvj1_pkg::word_t     op_a;
  rvj1_pkg::word_t     op_b;
  rvj1_pkg::word_t     alu_res;
  logic                lsu_busy;
  logic                lsu_wb_valid;
  rvj1_pkg::reg_addr_t lsu_wb_rd;
  rvj1_pkg::word_t     lsu_wb_data;
  logic                rf_we;
  rvj1_pkg::reg_addr_t rf_rd;
  rvj1_pkg::word_t     rf_data;

  ////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////
  rvj1_ifu rvj1_ifu_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .instr_req_o       (instr_req_o),
    .instr_req_valid_o (instr_req_valid_o),
    .instr_req_ready_i (instr_req_ready_i),
    .instr_rsp_i       (instr_rsp_i),
    .instr_rsp_valid_i (instr_rsp_valid_i),
    .instr_rsp_ready_o (instr_rsp_ready_o),
    .dec_instr_o       (fetch_instr),
    .dec_pc_o          (fetch_pc),
    .dec_valid_o       (fetch_valid),
    .dec_ready_i       (dec_ready),
    .jump_valid_i      (jump_valid),
    .jump_addr_i       (jump_addr)
  );

  rvj1_dec rvj1_dec_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ifu_instr_i   (fetch_instr),
    .ifu_pc_i      (fetch_pc),
    .ifu_valid_i   (fetch_valid),
    .ifu_ready_o   (dec_ready),
    .lsu_busy_i    (lsu_busy),
    .wb_valid_i    (lsu_wb_valid),
    .wb_rd_i       (lsu_wb_rd),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .issue_o       (issue),
    .issue_valid_o (issue_valid),
    .jump_valid_o  (jump_valid),
    .jump_addr_o   (jump_addr)
  );

  ////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////
  rvj1_regfile rvj1_regfile_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (rf_rd),
    .rd_data_i  (rf_data)
  );

  assign op_a = issue.use_pc  ? issue.pc  : rs1_data;
  assign op_b = issue.use_imm ? issue.imm : rs2_data;

  rvj1_alu rvj1_alu_i (
    .op_i  (issue.alu_op),
    .a_i   (op_a),
    .b_i   (op_b),
    .res_o (alu_res)
  );

  // Address from the ALU, store data straight from rs2
  rvj1_lsu rvj1_lsu_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .issue_valid_i    (issue_valid),
    .is_load_i        (issue.is_load),
    .is_store_i       (issue.is_store),
    .addr_i           (alu_res),
    .store_data_i     (rs2_data),
    .rd_i             (issue.rd),
    .busy_o           (lsu_busy),
    .data_req_o       (data_req_o),
    .data_req_valid_o (data_req_valid_o),
    .data_req_ready_i (data_req_ready_i),
    .data_rsp_i       (data_rsp_i),
    .data_rsp_valid_i (data_rsp_valid_i),
    .data_rsp_ready_o (data_rsp_ready_o),
    .wb_valid_o       (lsu_wb_valid),
    .wb_rd_o          (lsu_wb_rd),
    .wb_data_o        (lsu_wb_data)
  );

  ////////////////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////////////////
  // Load data wins, although decode never lets both happen at once
  assign rf_we = lsu_wb_valid || (issue_valid && (issue.alu_wb || issue.is_jump));
  assign rf_rd = lsu_wb_valid ? lsu_wb_rd : issue.rd;

  always_comb begin
    if (lsu_wb_valid) begin
      rf_data = lsu_wb_data;
    end else if (issue.is_jump) begin
      rf_data = issue.pc + rvj1_pkg::nbytes;
    end else begin
      rf_data = alu_res;
    end
  end

endmodule

//--- verif/rvj1_asserts.sv
/*
  Concurrent checks bound into rvj1_top. Bus requests hold steady under
  back-pressure, outputs stay low through reset and the two writeback
  sources never fire together.
*/

module rvj1_asserts (
  input logic               clk_i,
  input logic               rst_i,
  input rvj1_pkg::mem_req_t instr_req_i,
  input logic               instr_req_valid_i,
  input logic               instr_req_ready_i,
  input rvj1_pkg::mem_req_t data_req_i,
  input logic               data_req_valid_i,
  input logic               data_req_ready_i,
  input logic               issue_valid_i,
  input logic               core_wb_i,
  input logic               lsu_wb_valid_i,
  input logic               rf_we_i,
  input logic               jump_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_valid_i && !instr_req_ready_i |=> instr_req_valid_i && $stable(instr_req_i))
  else begin
    fail_count++;
    $error("instruction request changed before it was taken");
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_valid_i && !data_req_ready_i |=> data_req_valid_i && $stable(data_req_i))
  else begin
    fail_count++;
    $error("data request changed before it was taken");
  end

  // Registers are cleared one edge into reset
  assert property (@(posedge clk_i)
    rst_i |=> !(instr_req_valid_i || data_req_valid_i || issue_valid_i ||
                rf_we_i || jump_valid_i))
  else begin
    fail_count++;
    $error("valid or write enable high during reset");
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    !(lsu_wb_valid_i && issue_valid_i && core_wb_i))
  else begin
    fail_count++;
    $error("load writeback collided with an ALU or jump writeback");
  end

endmodule

bind rvj1_top rvj1_asserts rvj1_asserts_i (
  .clk_i             (clk_i),
  .rst_i             (rst_i),
  .instr_req_i       (instr_req_o),
  .instr_req_valid_i (instr_req_valid_o),
  .instr_req_ready_i (instr_req_ready_i),
  .data_req_i        (data_req_o),
  .data_req_valid_i  (data_req_valid_o),
  .data_req_ready_i  (data_req_ready_i),
  .issue_valid_i     (issue_valid),
  .core_wb_i         (issue.alu_wb || issue.is_jump),
  .lsu_wb_valid_i    (lsu_wb_valid),
  .rf_we_i           (rf_we),
  .jump_valid_i      (jump_valid)
);

//--- verif/rvj1_tb.sv
/*
  Testbench for the rvj1 core. Loads the program image, preloaded data
  words and the ordered list of expected stores from the tests file,
  models both memories and checks every store the core makes.
*/

module rvj1_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic               clk_i;
  logic               rst_i;
  rvj1_pkg::mem_req_t instr_req_o;
  logic               instr_req_valid_o;
  logic               instr_req_ready_i;
  rvj1_pkg::mem_rsp_t instr_rsp_i;
  logic               instr_rsp_valid_i;
  logic               instr_rsp_ready_o;
  rvj1_pkg::mem_req_t data_req_o;
  logic               data_req_valid_o;
  logic               data_req_ready_i;
  rvj1_pkg::mem_rsp_t data_rsp_i;
  logic               data_rsp_valid_i;
  logic               data_rsp_ready_o;

  // 256 words each, indexed by address bits 9:2
  rvj1_pkg::word_t imem [0:255];
  rvj1_pkg::word_t dmem [0:255];
  rvj1_pkg::word_t exp_addr [$];
  rvj1_pkg::word_t exp_data [$];
  int unsigned     n_prog;
  int unsigned     stores_seen;
  int unsigned     cycles;
  integer          seed;

  rvj1_top rvj1_top_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .instr_req_o       (instr_req_o),
    .instr_req_valid_o (instr_req_valid_o),
    .instr_req_ready_i (instr_req_ready_i),
    .instr_rsp_i       (instr_rsp_i),
    .instr_rsp_valid_i (instr_rsp_valid_i),
    .instr_rsp_ready_o (instr_rsp_ready_o),
    .data_req_o        (data_req_o),
    .data_req_valid_o  (data_req_valid_o),
    .data_req_ready_i  (data_req_ready_i),
    .data_rsp_i        (data_rsp_i),
    .data_rsp_valid_i  (data_rsp_valid_i),
    .data_rsp_ready_o  (data_rsp_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input string name, input rvj1_pkg::word_t got,
                            input rvj1_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_strobe(input string name, input rvj1_pkg::strobe_t got,
                              input rvj1_pkg::strobe_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                          $time, name, got, exp));
    end
  endtask

  // Word stores always carry a full strobe
  task automatic check_store(input rvj1_pkg::mem_req_t req);
    if (stores_seen >= exp_addr.size()) begin
      abort_run($sformatf("Unexpected store to address %h after the last expected store",
                          req.addr));
    end else begin
      check_word("data_req_o.addr", req.addr, exp_addr[stores_seen]);
      check_word("data_req_o.data", req.data, exp_data[stores_seen]);
      check_strobe("data_req_o.strobe", req.strobe, 4'hf);
      dmem[req.addr[9:2]] = req.data;
      stores_seen++;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests file
  //////////////////////////////////////////////////
  // Opcode field zero decodes as a no-op
  function automatic rvj1_pkg::word_t instr_fill(input rvj1_pkg::word_t addr);
    return {addr[31:7] ^ addr[24:0], 7'b0000000};
  endfunction

  function automatic rvj1_pkg::word_t data_fill(input rvj1_pkg::word_t addr);
    return ~addr;
  endfunction

  task automatic load_tests();
    int              fd;
    int              n;
    string           line;
    string           kind;
    rvj1_pkg::word_t addr;
    rvj1_pkg::word_t data;
    for (int i = 0; i < 256; i++) begin
      imem[i] = instr_fill(i * 4);
      dmem[i] = data_fill(i * 4);
    end
    fd = $fopen("verif/rvj1_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the tests file verif/rvj1_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h", kind, addr, data);
          if (n == 3) begin
            case (kind)
              "p": begin
                imem[addr[9:2]] = data;
                n_prog++;
              end
              "d": dmem[addr[9:2]] = data;
              "s": begin
                exp_addr.push_back(addr);
                exp_data.push_back(data);
              end
              default: abort_run("The tests file holds a line of unknown kind");
            endcase
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////
  // Handshakes sampled at the falling edge, answers driven after the rise
  initial begin
    rvj1_pkg::mem_req_t ireq;
    rvj1_pkg::mem_req_t dreq;
    logic               ifire;
    logic               irsp_done;
    logic               dfire;
    logic               drsp_done;
    logic               dpending;
    int                 ddelay;
    dpending = 1'b0;
    ddelay   = 0;
    forever begin
      @(negedge clk_i);
      ifire     = instr_req_valid_o && instr_req_ready_i;
      irsp_done = instr_rsp_valid_i && instr_rsp_ready_o;
      dfire     = data_req_valid_o && data_req_ready_i;
      drsp_done = data_rsp_valid_i && data_rsp_ready_o;
      ireq      = instr_req_o;
      dreq      = data_req_o;
      @(posedge clk_i);
      #5;
      if (irsp_done) begin
        instr_rsp_valid_i = 1'b0;
      end
      // Instruction memory answers one cycle after the request
      if (ifire) begin
        check_strobe("instr_req_o.strobe", ireq.strobe, 4'hf);
        if (ireq.write) begin
          abort_run("The instruction request asked for a write");
        end else begin
          instr_rsp_i       = '{data: imem[ireq.addr[9:2]], error: 1'b0};
          instr_rsp_valid_i = 1'b1;
        end
      end
      if (drsp_done) begin
        data_rsp_valid_i = 1'b0;
      end
      if (dfire) begin
        ddelay   = $random(seed) & 3;
        dpending = 1'b1;
        if (dreq.write) begin
          check_store(dreq);
        end else begin
          check_strobe("data_req_o.strobe", dreq.strobe, 4'hf);
          data_rsp_i = '{data: dmem[dreq.addr[9:2]], error: 1'b0};
        end
      end
      if (dpending) begin
        if (ddelay == 0) begin
          data_rsp_valid_i = 1'b1;
          dpending         = 1'b0;
        end else begin
          ddelay--;
        end
      end
      // Ready high about three cycles in four on both buses
      instr_req_ready_i = (($random(seed) & 3) != 0);
      data_req_ready_i  = (($random(seed) & 3) != 0);
    end
  end

  //////////////////////////////////////////////////
  // Reset, run and final verdict
  //////////////////////////////////////////////////
  initial begin
    int unsigned limit;
    rst_i             = 1'b1;
    instr_req_ready_i = 1'b1;
    instr_rsp_i       = '0;
    instr_rsp_valid_i = 1'b0;
    data_req_ready_i  = 1'b0;
    data_rsp_i        = '0;
    data_rsp_valid_i  = 1'b0;
    seed              = 54363;
    n_prog            = 0;
    stores_seen       = 0;
    cycles            = 0;
    load_tests();
    limit = 64 * n_prog;
    repeat (16) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    while (stores_seen < exp_addr.size() && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
      if (rvj1_top_i.rvj1_asserts_i.fail_count != 0) begin
        abort_run("A bound assertion on the core failed during the run");
      end
    end
    if (stores_seen < exp_addr.size()) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                          cycles, stores_seen, exp_addr.size()));
    end else if (rvj1_top_i.rvj1_asserts_i.fail_count != 0) begin
      abort_run("A bound assertion on the core failed during the run");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- verif/rvj1_tests.txt
# kind address data, all hex
# p = program word, d = preloaded data word, s = expected store in order
p 00000000 12300093
p 00000004 f0000113
p 00000008 002081b3
p 0000000c 30302023
p 00000010 40208233
p 00000014 30402223
p 00000018 0020f2b3
p 0000001c 30502423
p 00000020 0020e333
p 00000024 30602623
p 00000028 0020c3b3
p 0000002c 30702823
p 00000030 abcde437
p 00000034 30802a23
p 00000038 20002483
p 0000003c 00148513
p 00000040 30a02c23
p 00000044 05508013
p 00000048 30002e23
p 0000004c 008005ef
p 00000050 3e102823
p 00000054 32b02023
p 00000058 20402603
p 0000005c 32c02223
p 00000060 0000006f
d 00000200 12345678
d 00000204 cafef00d
s 00000300 00000023
s 00000304 00000223
s 00000308 00000100
s 0000030c ffffff23
s 00000310 fffffe23
s 00000314 abcde000
s 00000318 12345679
s 0000031c 00000000
s 00000320 00000050
s 00000324 cafef00d

//--- verilog.f
common/rvj1_pkg.sv
ifu/rvj1_ifu.sv
dec/rvj1_dec.sv
rtl/rvj1_regfile.sv
rtl/rvj1_alu.sv
lsu/rvj1_lsu.sv
rtl/rvj1_top.sv
verif/rvj1_asserts.sv
verif/rvj1_tb.sv
